// File: rv_core.f
+incdir+source
source/rv_pkg.sv
source/if_stage.sv
source/id_stage.sv
source/regfile.sv
source/exe_stage.sv
source/rv_core.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/if_stage.sv
      - source/id_stage.sv
      - source/regfile.sv
      - source/exe_stage.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/rv_core_assertions.sv
      - test/rv_core_tb.sv

// File: test/rv_core_tb.sv
// rv_core testbench; memory decodes adr[11:2] only and acks 1 to 4 cycles after a request
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;
	import rv_pkg::*;

	typedef struct packed {
		logic      we;
		logic      taken;
		logic      has_data;
		reg_addr_t rd;
		xword_t    data;
		xword_t    next_pc;
	} expect_t;

	logic clk = 1'b0;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic [`ADR_W-1:0] wb_adr;
	inst_t wb_dat_i;
	logic wb_ack;
	logic retire_valid;
	xword_t retire_pc;
	inst_t retire_inst;
	logic retire_we;
	reg_addr_t retire_rd;
	xword_t retire_data;
	logic retire_taken;

	inst_t mem [1024];
	inst_t give_dat;
	logic give_ack;
	logic busy;
	int waits;
	integer seed;
	int prog_len;
	xword_t seg_end [6]; // last entry is the halt pc
	string seg_name [6];
	int seg_cnt [6];
	int seg_exp [6];
	int seg_err [6];
	int cur_seg;
	int err_count;
	int retired;
	int exp_total;
	bit halted;
	bit timed_out;
	xword_t model_pc;
	xword_t model_regs [32];
	expect_t ex;

	rv_core dut (
		.clk          (clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_ack       (wb_ack),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_we    (retire_we),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.retire_taken (retire_taken)
	);

	always #50 clk = ~clk;

	// request seen at the falling edge, ack driven after the next rising edge
	always @(negedge clk) begin
		give_ack = 1'b0;
		if (rst) begin
			busy = 1'b0;
		end else if (wb_cyc && wb_stb && !wb_ack) begin
			if (!busy) begin
				busy = 1'b1;
				waits = $unsigned($random(seed)) % 4;
			end
			if (waits == 0) begin
				give_ack = 1'b1;
				give_dat = mem[wb_adr[11:2]];
				busy = 1'b0;
			end else begin
				waits--;
			end
		end
	end

	always @(posedge clk) begin
		#1;
		wb_ack = give_ack;
		wb_dat_i = give_dat;
	end

	function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3, reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
		reg_addr_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	function automatic inst_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
		logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic reg_addr_t rnd_reg();
		return reg_addr_t'($unsigned($random(seed)) % 19 + 1); // x1..x19
	endfunction

	task automatic emit(inst_t word);
		mem[prog_len] = word;
		prog_len++;
	endtask

	task automatic build_program();
		int j;
		logic [2:0] f3;
		logic [11:0] imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		for (int i = 0; i < 1024; i++)
			mem[i] = {20'(i), 12'h00f}; // fence, index in the upper bits
		prog_len = 0;
		for (int r = 1; r < 20; r++) begin
			emit({20'($random(seed)), 5'(r), OPC_LUI});
			emit(enc_i(12'($random(seed)), 5'(r), F3_ADD_SUB, 5'(r)));
		end
		seg_end[0] = xword_t'(prog_len * 4);
		for (int k = 0; k < 40; k++) begin
			j = k % 10;
			rs1 = rnd_reg();
			rs2 = rnd_reg();
			rd = rnd_reg();
			f3 = (j < 8) ? 3'(j) : ((j == 8) ? F3_ADD_SUB : F3_SR);
			emit(enc_r((j < 8) ? F7_BASE : F7_ALT, rs2, rs1, f3, rd));
			imm = 12'($random(seed));
			f3 = (j < 8) ? 3'(j) : ((j == 8) ? F3_SR : F3_ADD_SUB);
			if (f3 == F3_SLL || f3 == F3_SR)
				imm[11:6] = (j == 8) ? 6'b010000 : 6'b000000; // srai on j 8
			rs1 = rnd_reg();
			rd = rnd_reg();
			emit(enc_i(imm, rs1, f3, rd));
		end
		seg_end[1] = xword_t'(prog_len * 4);
		emit({20'($random(seed)) | 20'h80000, 5'd26, OPC_LUI});
		emit({20'($random(seed)) & 20'h7ffff, 5'd27, OPC_LUI});
		emit({20'($random(seed)), 5'd0, OPC_LUI});
		emit(enc_i(12'd123, 5'd0, F3_ADD_SUB, 5'd0));
		emit(enc_r(F7_BASE, 5'd26, 5'd0, F3_ADD_SUB, 5'd28));
		emit(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd29));
		seg_end[2] = xword_t'(prog_len * 4);
		emit(enc_i(12'hffb, 5'd0, F3_ADD_SUB, 5'd21)); // -5, below 7 signed, above unsigned
		emit(enc_i(12'd7, 5'd0, F3_ADD_SUB, 5'd22));
		for (int c = 0; c < 6; c++) begin
			f3 = (c < 2) ? 3'(c) : 3'(c + 2);
			emit(enc_b(13'd8, 5'd21, 5'd21, f3));
			emit(enc_i(12'd1, 5'd23, F3_ADD_SUB, 5'd23));
			emit(enc_b(13'd8, 5'd22, 5'd21, f3));
			emit(enc_i(12'd1, 5'd23, F3_ADD_SUB, 5'd23));
			emit(enc_b(13'd8, 5'd21, 5'd22, f3));
			emit(enc_i(12'd1, 5'd23, F3_ADD_SUB, 5'd23));
		end
		seg_end[3] = xword_t'(prog_len * 4);
		emit(enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd20));
		emit(enc_i(12'd3, 5'd24, F3_ADD_SUB, 5'd24));
		emit(enc_i(12'hfff, 5'd20, F3_ADD_SUB, 5'd20));
		emit(enc_b(13'h1ff8, 5'd0, 5'd20, F3_BNE)); // back to the addi x24
		seg_end[4] = xword_t'(prog_len * 4);
		emit({12'h000, 5'd1, 3'b011, 5'd5, 7'b0000011}); // ld x5 is not supported
		emit(32'h0000_0073);
		emit(enc_r(F7_BASE, 5'd0, 5'd5, F3_ADD_SUB, 5'd25));
		seg_end[5] = xword_t'(prog_len * 4);
		emit(enc_b(13'd0, 5'd0, 5'd0, F3_BEQ)); // halt, branches to itself
	endtask

	// expected retire from RV64I rules, regs[0] is never written
	function automatic expect_t ref_step(input xword_t pc, input xword_t regs [32],
		input inst_t word);
		expect_t e;
		xword_t a;
		xword_t b;
		logic ok;
		logic is_op;
		logic base;
		logic alt;
		logic [5:0] sh;
		a = regs[word[19:15]];
		b = regs[word[24:20]];
		is_op = (word[6:0] == OPC_OP);
		base = is_op ? (word[31:25] == 7'h00) : (word[31:26] == 6'h00);
		alt = is_op ? (word[31:25] == 7'h20) : (word[31:26] == 6'h10);
		e = '0;
		e.rd = word[11:7];
		e.next_pc = pc + 4;
		ok = 1'b1;
		case (word[6:0])
			OPC_LUI: e.data = {{32{word[31]}}, word[31:12], 12'h000};
			OPC_OP, OPC_OP_IMM: begin
				if (!is_op)
					b = {{52{word[31]}}, word[31:20]};
				sh = b[5:0];
				case (word[14:12])
					3'd0: begin
						e.data = (is_op && alt) ? a - b : a + b;
						ok = !is_op || base || alt;
					end
					3'd1: begin
						e.data = a << sh;
						ok = base;
					end
					3'd5: begin
						e.data = alt ? xword_t'($signed(a) >>> sh) : a >> sh;
						ok = base || alt;
					end
					3'd2: e.data = xword_t'($signed(a) < $signed(b));
					3'd3: e.data = xword_t'(a < b);
					3'd4: e.data = a ^ b;
					3'd6: e.data = a | b;
					default: e.data = a & b;
				endcase
				if (word[14:12] inside {3'd2, 3'd3, 3'd4, 3'd6, 3'd7})
					ok = !is_op || base;
			end
			OPC_BRANCH: begin
				case (word[14:12])
					3'd0: e.taken = (a == b);
					3'd1: e.taken = (a != b);
					3'd4: e.taken = ($signed(a) < $signed(b));
					3'd5: e.taken = ($signed(a) >= $signed(b));
					3'd6: e.taken = (a < b);
					3'd7: e.taken = (a >= b);
					default: ok = 1'b0;
				endcase
				e.data = xword_t'(e.taken);
				if (e.taken)
					e.next_pc = pc + {{51{word[31]}}, word[31], word[7], word[30:25],
						word[11:8], 1'b0};
			end
			default: ok = 1'b0;
		endcase
		e.we = ok && (word[6:0] != OPC_BRANCH);
		e.has_data = ok;
		return e;
	endfunction

	function automatic int seg_of(xword_t pc);
		int s;
		s = 5;
		for (int t = 4; t >= 0; t--)
			if (pc < seg_end[t])
				s = t;
		return s;
	endfunction

	task automatic count_expected();
		xword_t pc;
		xword_t regs [32];
		expect_t e;
		pc = `RESET_PC;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		exp_total = 0;
		while (pc != seg_end[5] && exp_total < 10000) begin
			e = ref_step(pc, regs, mem[pc[11:2]]);
			seg_exp[seg_of(pc)]++;
			exp_total++;
			if (e.we && e.rd != 5'd0)
				regs[e.rd] = e.data;
			pc = e.next_pc;
		end
	endtask

	task automatic report_mismatch(string msg);
		$display("ERR %0t: %s", $time, msg);
		err_count++;
		seg_err[cur_seg]++;
	endtask

	task automatic check_word(string what, xword_t got, xword_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_inst(string what, inst_t got, inst_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	task automatic check_rd(string what, reg_addr_t got, reg_addr_t exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is x%0d, expected x%0d", what, got, exp));
	endtask

	// kind 0 request, 1 ack, 2 end of test t, 3 halt reached
	task automatic wait_event(int kind, int t, string what, int limit);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		while (!done && !timed_out) begin
			if (kind < 2)
				@(negedge clk);
			else
				@(posedge clk); // model state moves on the falling edge
			case (kind)
				0: done = wb_cyc;
				1: done = wb_ack;
				2: done = (model_pc >= seg_end[t]) || halted;
				default: done = halted;
			endcase
			n++;
			if (!done && n >= limit) begin
				$display("timeout: no %s within %0d cycles", what, limit);
				timed_out = 1'b1;
			end
		end
	endtask

	// compare process, outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst && retire_valid && !halted) begin
			if (retire_pc == seg_end[5]) begin // the dut's own pc ends the count
				check_word("retire_pc at halt", retire_pc, model_pc);
				halted = 1'b1;
			end else begin
				cur_seg = seg_of(model_pc);
				ex = ref_step(model_pc, model_regs, mem[model_pc[11:2]]);
				check_word("retire_pc", retire_pc, model_pc);
				check_inst("retire_inst", retire_inst, mem[model_pc[11:2]]);
				check_bit("retire_we", retire_we, ex.we);
				check_bit("retire_taken", retire_taken, ex.taken);
				if (ex.we)
					check_rd("retire_rd", retire_rd, ex.rd);
				if (ex.has_data)
					check_word("retire_data", retire_data, ex.data);
				if (ex.we && ex.rd != 5'd0)
					model_regs[ex.rd] = ex.data;
				model_pc = ex.next_pc;
				retired++;
				seg_cnt[cur_seg]++;
			end
		end
	end

	initial begin
		rst = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		give_ack = 1'b0;
		give_dat = '0;
		busy = 1'b0;
		waits = 0;
		seed = 32'h03825c05;
		err_count = 0;
		retired = 0;
		cur_seg = 0;
		halted = 1'b0;
		timed_out = 1'b0;
		model_pc = `RESET_PC;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		for (int t = 0; t < 6; t++) begin
			seg_cnt[t] = 0;
			seg_exp[t] = 0;
			seg_err[t] = 0;
		end
		seg_name = '{"seed registers", "alu ops", "lui and x0", "branches",
			"counted loop", "unsupported opcode"};
		build_program();
		count_expected();
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		wait_event(0, 0, "first fetch request", 20);
		if (!timed_out)
			check_word("first fetch address", xword_t'(wb_adr), xword_t'(`RESET_PC));
		wait_event(1, 0, "first ack", 20);
		for (int t = 0; t < 6; t++) begin
			if (!timed_out) begin
				wait_event(2, t, $sformatf("end of test %0d", t), 2000);
				$display("test %0d %s: %0d of %0d retired, %0d errors", t, seg_name[t],
					seg_cnt[t], seg_exp[t], seg_err[t]);
			end
		end
		wait_event(3, 0, "retire at the halt loop", 100);
		if (!timed_out && retired != exp_total) begin
			$display("retire count %0d does not match the reference count %0d",
				retired, exp_total);
			err_count++;
		end
		if (dut.u_assertions.fails != 0) begin
			$display("%0d bus or retire assertions failed", dut.u_assertions.fails);
			err_count += dut.u_assertions.fails;
		end
		$display("summary: %0d retired, %0d expected, %0d errors", retired, exp_total,
			err_count);
		if (timed_out || err_count != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: test/rv_core_assertions.sv
// bound into rv_core, sampled on clk; reset checks start one cycle after rst is first seen high
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_assertions (
	input logic              clk,
	input logic              rst,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic [`ADR_W-1:0] wb_adr,
	input logic              wb_ack,
	input logic              retire_valid
);

	int fails = 0; // failed assertion count

	a_cyc_is_stb: assert property (@(posedge clk) wb_cyc == wb_stb)
		else begin
			$error("wb_cyc and wb_stb differ");
			fails++;
		end

	// address held until the slave acks
	a_adr_stable: assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && !wb_ack) |=> $stable(wb_adr))
		else begin
			$error("wb_adr changed during a pending request");
			fails++;
		end

	a_retire_after_ack: assert property (@(posedge clk) disable iff (rst)
		retire_valid == $past(wb_cyc && wb_ack))
		else begin
			$error("retire_valid is not the cycle after ack");
			fails++;
		end

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> (!rst || (!wb_cyc && !retire_valid)))
		else begin
			$error("bus request or retire while in reset");
			fails++;
		end

endmodule

bind rv_core rv_core_assertions u_assertions (
	.clk          (clk),
	.rst          (rst),
	.wb_cyc       (wb_cyc),
	.wb_stb       (wb_stb),
	.wb_adr       (wb_adr),
	.wb_ack       (wb_ack),
	.retire_valid (retire_valid)
);

// File: source/rv_core.sv
// RV64I subset core top; one instruction in flight, retire port has no back-pressure
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
	input  logic               clk,
	input  logic               rst,

	output logic               wb_cyc,
	output logic               wb_stb,
	output logic [`ADR_W-1:0]  wb_adr,
	input  rv_pkg::inst_t      wb_dat_i,
	input  logic               wb_ack,

	output logic               retire_valid,
	output rv_pkg::xword_t     retire_pc,
	output rv_pkg::inst_t      retire_inst,
	output logic               retire_we,
	output rv_pkg::reg_addr_t  retire_rd,
	output rv_pkg::xword_t     retire_data,
	output logic               retire_taken
);
	import rv_pkg::*;

	inst_t     inst;
	xword_t    pc;
	logic      exec_valid;
	logic      branch_taken;
	logic      rs1_r_ena;
	logic      rs2_r_ena;
	logic      rd_w_ena;
	reg_addr_t rs1_r_addr;
	reg_addr_t rs2_r_addr;
	reg_addr_t rd_w_addr;
	xword_t    rs1_data;
	xword_t    rs2_data;
	alu_op_t   alu_op;
	xword_t    op1;
	xword_t    op2;
	logic      branch;
	xword_t    b_offset;
	xword_t    result;
	logic      cmp_true;

	assign branch_taken = branch & cmp_true;

	if_stage u_if (
		.clk          (clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_ack       (wb_ack),
		.inst         (inst),
		.pc           (pc),
		.exec_valid   (exec_valid),
		.branch_taken (branch_taken),
		.b_offset     (b_offset)
	);

	id_stage u_id (
		.rst        (rst),
		.inst       (inst),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.rs1_r_ena  (rs1_r_ena),
		.rs1_r_addr (rs1_r_addr),
		.rs2_r_ena  (rs2_r_ena),
		.rs2_r_addr (rs2_r_addr),
		.rd_w_ena   (rd_w_ena),
		.rd_w_addr  (rd_w_addr),
		.alu_op     (alu_op),
		.op1        (op1),
		.op2        (op2),
		.branch     (branch),
		.b_offset   (b_offset)
	);

	regfile u_rf (
		.clk     (clk),
		.rst     (rst),
		.we      (exec_valid & rd_w_ena), // decode is only meaningful in execute
		.w_addr  (rd_w_addr),
		.w_data  (result),
		.r1_ena  (rs1_r_ena),
		.r1_addr (rs1_r_addr),
		.r1_data (rs1_data),
		.r2_ena  (rs2_r_ena),
		.r2_addr (rs2_r_addr),
		.r2_data (rs2_data)
	);

	exe_stage u_exe (
		.alu_op   (alu_op),
		.op1      (op1),
		.op2      (op2),
		.result   (result),
		.cmp_true (cmp_true)
	);

	// retire reports the execute cycle as it happens
	assign retire_valid = exec_valid;
	assign retire_pc    = pc;
	assign retire_inst  = inst;
	assign retire_we    = rd_w_ena;
	assign retire_rd    = rd_w_addr;
	assign retire_data  = result;
	assign retire_taken = branch_taken;

endmodule

// File: source/exe_stage.sv
// integer ALU and branch compare; branch ops return the compare bit as result, no W forms
`timescale 1ns/1ps
`include "rv_cfg.svh"

module exe_stage (
	input  rv_pkg::alu_op_t  alu_op,
	input  rv_pkg::xword_t   op1,
	input  rv_pkg::xword_t   op2,

	output rv_pkg::xword_t   result,
	output logic             cmp_true
);
	import rv_pkg::*;

	logic [$clog2(`XLEN)-1:0] sh; // low 6 bits of op2
	logic lt_s;
	logic lt_u;
	logic eq;

	assign sh = op2[$clog2(`XLEN)-1:0];
	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;
	assign eq = (op1 == op2);

	always_comb begin
		case (alu_op)
			ALU_BEQ:  cmp_true = eq;
			ALU_BNE:  cmp_true = ~eq;
			ALU_BLT:  cmp_true = lt_s;
			ALU_BGE:  cmp_true = ~lt_s;
			ALU_BLTU: cmp_true = lt_u;
			ALU_BGEU: cmp_true = ~lt_u;
			default:  cmp_true = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = op1 + op2;
			ALU_SUB:  result = op1 - op2;
			ALU_SLT:  result = xword_t'(lt_s);
			ALU_SLTU: result = xword_t'(lt_u);
			ALU_XOR:  result = op1 ^ op2;
			ALU_OR:   result = op1 | op2;
			ALU_AND:  result = op1 & op2;
			ALU_SLL:  result = op1 << sh;
			ALU_SRL:  result = op1 >> sh;
			ALU_SRA:  result = $signed(op1) >>> sh; // keeps sign
			ALU_LUI:  result = op2;
			ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
				result = xword_t'(cmp_true);
			end
			default:  result = '0;
		endcase
	end

endmodule

// File: source/regfile.sv
// 32 x XLEN register file, two asynchronous read ports, x0 reads zero and ignores writes
`timescale 1ns/1ps
`include "rv_cfg.svh"

module regfile (
	input  logic               clk,
	input  logic               rst,

	input  logic               we,
	input  rv_pkg::reg_addr_t  w_addr,
	input  rv_pkg::xword_t     w_data,

	input  logic               r1_ena,
	input  rv_pkg::reg_addr_t  r1_addr,
	output rv_pkg::xword_t     r1_data,

	input  logic               r2_ena,
	input  rv_pkg::reg_addr_t  r2_addr,
	output rv_pkg::xword_t     r2_data
);
	import rv_pkg::*;

	xword_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we && w_addr != '0) begin
			regs[w_addr] <= w_data;
		end
	end

	// no bypass, write lands after the execute cycle
	assign r1_data = (r1_ena && r1_addr != '0) ? regs[r1_addr] : '0;
	assign r2_data = (r2_ena && r2_addr != '0) ? regs[r2_addr] : '0;

endmodule

// File: source/id_stage.sv
// combinational decode for OP, OP-IMM, LUI and BRANCH; anything else decodes to a no-op
`timescale 1ns/1ps
`include "rv_cfg.svh"

module id_stage (
	input  logic               rst,
	input  rv_pkg::inst_t      inst,
	input  rv_pkg::xword_t     rs1_data,
	input  rv_pkg::xword_t     rs2_data,

	output logic               rs1_r_ena,
	output rv_pkg::reg_addr_t  rs1_r_addr,
	output logic               rs2_r_ena,
	output rv_pkg::reg_addr_t  rs2_r_addr,
	output logic               rd_w_ena,
	output rv_pkg::reg_addr_t  rd_w_addr,

	output rv_pkg::alu_op_t    alu_op,
	output rv_pkg::xword_t     op1,
	output rv_pkg::xword_t     op2,
	output logic               branch,
	output rv_pkg::xword_t     b_offset
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [5:0] funct6; // shift immediates keep bit 25 for shamt

	xword_t imm_i;
	xword_t imm_u;
	xword_t imm_b;
	xword_t shamt;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign funct6 = inst[31:26];

	assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign shamt = xword_t'(inst[25:20]);

	assign rs1_r_addr = rst ? '0 : inst[19:15];
	assign rs2_r_addr = rst ? '0 : inst[24:20];
	assign rd_w_addr  = rst ? '0 : inst[11:7];
	assign b_offset   = imm_b;

	always_comb begin
		rs1_r_ena = 1'b0;
		rs2_r_ena = 1'b0;
		rd_w_ena = 1'b0;
		branch = 1'b0;
		op1 = '0;
		op2 = '0;
		alu_op = ALU_ZERO;
		if (!rst) begin
			case (opcode)
				OPC_OP_IMM: begin
					rs1_r_ena = 1'b1;
					rd_w_ena = 1'b1;
					op1 = rs1_data;
					op2 = imm_i;
					case (funct3)
						F3_ADD_SUB: alu_op = ALU_ADD;
						F3_SLT:     alu_op = ALU_SLT;
						F3_SLTU:    alu_op = ALU_SLTU;
						F3_XOR:     alu_op = ALU_XOR;
						F3_OR:      alu_op = ALU_OR;
						F3_AND:     alu_op = ALU_AND;
						F3_SLL: begin
							op2 = shamt;
							if (funct6 == F7_BASE[6:1])
								alu_op = ALU_SLL;
						end
						F3_SR: begin
							op2 = shamt;
							if (funct6 == F7_BASE[6:1])
								alu_op = ALU_SRL;
							else if (funct6 == F7_ALT[6:1])
								alu_op = ALU_SRA;
						end
						default: alu_op = ALU_ZERO;
					endcase
				end
				OPC_OP: begin
					rs1_r_ena = 1'b1;
					rs2_r_ena = 1'b1;
					rd_w_ena = 1'b1;
					op1 = rs1_data;
					op2 = rs2_data;
					if (funct7 == F7_BASE) begin
						case (funct3)
							F3_ADD_SUB: alu_op = ALU_ADD;
							F3_SLL:     alu_op = ALU_SLL;
							F3_SLT:     alu_op = ALU_SLT;
							F3_SLTU:    alu_op = ALU_SLTU;
							F3_XOR:     alu_op = ALU_XOR;
							F3_SR:      alu_op = ALU_SRL;
							F3_OR:      alu_op = ALU_OR;
							default:    alu_op = ALU_AND;
						endcase
					end else if (funct7 == F7_ALT) begin
						if (funct3 == F3_ADD_SUB)
							alu_op = ALU_SUB;
						else if (funct3 == F3_SR)
							alu_op = ALU_SRA;
					end
				end
				OPC_LUI: begin
					rd_w_ena = 1'b1;
					op2 = imm_u; // op1 stays zero
					alu_op = ALU_LUI;
				end
				OPC_BRANCH: begin
					rs1_r_ena = 1'b1;
					rs2_r_ena = 1'b1;
					branch = 1'b1;
					op1 = rs1_data;
					op2 = rs2_data;
					case (funct3)
						F3_BEQ:  alu_op = ALU_BEQ;
						F3_BNE:  alu_op = ALU_BNE;
						F3_BLT:  alu_op = ALU_BLT;
						F3_BGE:  alu_op = ALU_BGE;
						F3_BLTU: alu_op = ALU_BLTU;
						F3_BGEU: alu_op = ALU_BGEU;
						default: alu_op = ALU_ZERO;
					endcase
				end
				default: alu_op = ALU_ZERO;
			endcase

			// illegal funct fields fall back to a no-op
			if (alu_op == ALU_ZERO) begin
				rs1_r_ena = 1'b0;
				rs2_r_ena = 1'b0;
				rd_w_ena = 1'b0;
				branch = 1'b0;
				op1 = '0;
				op2 = '0;
			end
		end
	end

endmodule

// File: source/if_stage.sv
// fetch and phase control; one instruction in flight, read-only Wishbone classic, no bus errors
`timescale 1ns/1ps
`include "rv_cfg.svh"

module if_stage (
	input  logic               clk,
	input  logic               rst,

	output logic               wb_cyc,
	output logic               wb_stb,
	output logic [`ADR_W-1:0]  wb_adr,
	input  rv_pkg::inst_t      wb_dat_i,
	input  logic               wb_ack,

	output rv_pkg::inst_t      inst,
	output rv_pkg::xword_t     pc,
	output logic               exec_valid,
	input  logic               branch_taken,
	input  rv_pkg::xword_t     b_offset
);
	import rv_pkg::*;

	typedef enum logic {
		FETCH,
		EXEC
	} phase_t;

	phase_t phase;
	xword_t pc_next;

	// request in the very first cycle out of reset
	assign wb_cyc = ~rst & (phase == FETCH);
	assign wb_stb = wb_cyc;
	assign wb_adr = pc[`ADR_W-1:0];

	assign exec_valid = (phase == EXEC);

	// taken branch is pc relative
	assign pc_next = branch_taken ? pc + b_offset : pc + xword_t'(4);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= FETCH;
			pc <= xword_t'(`RESET_PC);
		end else begin
			case (phase)
				FETCH: begin
					if (wb_ack) // wait states just hold here
						phase <= EXEC;
				end
				EXEC: begin
					phase <= FETCH;
					pc <= pc_next;
				end
				default: begin
					phase <= FETCH;
				end
			endcase
		end
	end

	// instruction register, loaded in the ack cycle
	always_ff @(posedge clk) begin
		if (wb_cyc && wb_ack)
			inst <= wb_dat_i;
	end

endmodule

// File: source/rv_pkg.sv
// shared types and RV64I encodings for the core; only OP, OP-IMM, LUI and BRANCH are listed
`include "rv_cfg.svh"

package rv_pkg;

	typedef logic [`XLEN-1:0]   xword_t;
	typedef logic [`INST_W-1:0] inst_t;
	typedef logic [4:0]         reg_addr_t;

	typedef enum logic [4:0] {
		ALU_ZERO, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_t;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101; // srl or sra by funct7
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct3 for BRANCH
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct7, alt selects sub and sra
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: source/rv_cfg.svh
// project-wide sizes and reset PC; the decoder takes 6-bit shift amounts so XLEN must stay 64
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// register and data width
`define XLEN 64

// instruction word and Wishbone data width
`define INST_W 32

// Wishbone address width, the low part of the PC
`define ADR_W 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_0000_0000

// number of integer registers, x0 included
`define NUM_REGS 32

`endif
